//--- verilog.f
+incdir+.
noc_pkg.sv
route_compute.sv
vc_buffer.sv
input_port.sv
tb_clk_gen.sv
input_port_chk.sv
tb_input_port.sv

//--- Bender.yml
package:
  name: noc_input_port

export_include_dirs:
  - .

sources:
  - noc_pkg.sv
  - route_compute.sv
  - vc_buffer.sv
  - input_port.sv
  - target: test
    files:
      - tb_clk_gen.sv
      - input_port_chk.sv
      - tb_input_port.sv

//--- tb_input_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module tb_input_port;

    import noc_pkg::*;

    localparam int CLK_PERIOD = 10;
    localparam int NUM_TESTS  = 6;
    localparam int VC_NUM     = `NOC_VC_NUM;
    localparam int OFF_LEVEL  = `NOC_BUFFER_SIZE - `NOC_ON_OFF_MARGIN;

    logic                     clk;
    logic                     arst_n;
    flit_t                    link_flit;
    logic                     link_valid;
    logic [`NOC_VC_SIZE-1:0]  vc_sel;
    logic                     sa_valid;
    logic [`NOC_VC_SIZE-1:0]  vc_new [VC_NUM];
    logic [VC_NUM-1:0]        vc_valid;
    flit_t                    out_flit;
    logic                     out_valid;
    logic [VC_NUM-1:0]        on_off;
    logic [VC_NUM-1:0]        allocatable;
    logic [VC_NUM-1:0]        request;
    port_t [VC_NUM-1:0]       out_port;
    flit_t                    model_q [VC_NUM][$];  // Expected flits per VC in write order
    logic [`NOC_VC_SIZE-1:0]  granted [VC_NUM];
    integer                   seed;
    string                    test_name;
    int                       errors;
    int                       errors_seen;
    int                       tests_failed;

    tb_clk_gen #(
        .PERIOD       (CLK_PERIOD),
        .RESET_CYCLES (5)
    ) tb_clk_gen_i (
        .clk_o    (clk),
        .arst_n_o (arst_n)
    );

    input_port #(
        .X_CURRENT (1),
        .Y_CURRENT (1)
    ) input_port_i (
        .clk              (clk),
        .arst_n_i         (arst_n),
        .data_i           (link_flit),
        .valid_flit_i     (link_valid),
        .vc_sel_i         (vc_sel),
        .sa_valid_i       (sa_valid),
        .vc_new_i         (vc_new),
        .vc_valid_i       (vc_valid),
        .flit_o           (out_flit),
        .flit_valid_o     (out_valid),
        .on_off_o         (on_off),
        .vc_allocatable_o (allocatable),
        .vc_request_o     (request),
        .out_port_o       (out_port)
    );

    task automatic step();
        @(posedge clk);
        #1;
    endtask

    function automatic int total_errors();
        return errors + int'(input_port_i.input_port_chk_i.fail_count);
    endfunction

    task automatic check_value(input string what, input logic [31:0] expected,
                               input logic [31:0] actual);
        assert (actual === expected)
        else
        begin
            $display("[ERROR] %s %s: expected %0h, actual %0h", test_name, what, expected, actual);
            errors++;
        end
    endtask

    task automatic begin_test(input string name);
        test_name   = name;
        errors_seen = total_errors();
    endtask

    task automatic end_test();
        if (total_errors() == errors_seen)
        begin
            $display("Test %s: PASS", test_name);
        end
        else
        begin
            $display("Test %s: FAIL with %0d errors", test_name, total_errors() - errors_seen);
            tests_failed++;
        end
    endtask

    function automatic flit_data_u random_payload();
        flit_data_u d;
        d.bt_pl = `NOC_PAYLOAD_WIDTH'($random(seed));
        return d;
    endfunction

    function automatic flit_data_u head_payload(input int x, input int y);
        flit_data_u d;
        d = random_payload();  // Random padding under the destination
        d.head_data.x_dest = `NOC_DEST_ADDR_SIZE_X'(x);
        d.head_data.y_dest = `NOC_DEST_ADDR_SIZE_Y'(y);
        return d;
    endfunction

    // Puts a flit on the link for the next edge and records it as expected
    task automatic drive_flit(input int vc, input flit_type_e ftype, input flit_data_u payload);
        link_flit.flit_type = ftype;
        link_flit.vc_id     = `NOC_VC_SIZE'(vc);
        link_flit.data      = payload;
        link_valid          = 1'b1;
        model_q[vc].push_back(link_flit);
    endtask

    task automatic send_flit(input int vc, input flit_type_e ftype, input flit_data_u payload);
        drive_flit(vc, ftype, payload);
        step();
        link_valid = 1'b0;
    endtask

    task automatic grant_vc(input int vc, input int new_vc);
        vc_valid[vc] = 1'b1;
        vc_new[vc]   = `NOC_VC_SIZE'(new_vc);
        granted[vc]  = `NOC_VC_SIZE'(new_vc);
        step();
        vc_valid[vc] = 1'b0;
    endtask

    task automatic compare_front(input int vc);
        flit_t expected;
        if (model_q[vc].size() == 0)
        begin
            $display("Test %s: VC %0d delivered a flit that was never sent", test_name, vc);
            errors++;
        end
        else
        begin
            expected = model_q[vc].pop_front();
            check_value("flit type", expected.flit_type, out_flit.flit_type);
            check_value("payload", expected.data.bt_pl, out_flit.data.bt_pl);
            check_value("vc id", granted[vc], out_flit.vc_id);  // Downstream VC, not link VC
        end
    endtask

    // Requests a pop and samples the crossbar side mid cycle, where it is stable
    task automatic pop_flit(input int vc);
        int waited;
        waited   = 0;
        vc_sel   = `NOC_VC_SIZE'(vc);
        sa_valid = 1'b1;
        @(negedge clk);
        while (!out_valid && waited < 20)
        begin
            step();
            @(negedge clk);
            waited++;
        end
        if (out_valid)
        begin
            compare_front(vc);
        end
        else
        begin
            $display("Test %s: timed out waiting for a valid flit on VC %0d", test_name, vc);
            errors++;
        end
        step();
        sa_valid = 1'b0;
    endtask

    task automatic verify_reset_state();
        begin_test("reset_state");
        check_value("on_off", {VC_NUM{1'b1}}, on_off);
        check_value("allocatable", {VC_NUM{1'b1}}, allocatable);
        check_value("request", 0, request);
        check_value("flit valid", 0, out_valid);
        end_test();
    endtask

    task automatic route_heads();
        int    xs [8]    = '{1, 3, 0, 1, 1, 2, 0, 3};
        int    ys [8]    = '{1, 1, 1, 3, 0, 0, 3, 2};
        port_t ports [8] = '{LOCAL, EAST, WEST, SOUTH, NORTH, EAST, WEST, EAST};
        begin_test("xy_routing");
        foreach (xs[i])
        begin
            send_flit(0, HEADTAIL, head_payload(xs[i], ys[i]));
            check_value("out port", ports[i], out_port[0]);
            grant_vc(0, i % 2);
            pop_flit(0);
        end
        end_test();
    endtask

    task automatic allocate_vc();
        begin_test("vc_allocation");
        send_flit(1, HEAD, head_payload(2, 1));
        check_value("request after head", 1, request[1]);
        check_value("allocatable after head", 0, allocatable[1]);
        check_value("route after head", EAST, out_port[1]);
        send_flit(1, BODY, random_payload());
        send_flit(1, TAIL, random_payload());
        check_value("route held over body", EAST, out_port[1]);
        grant_vc(1, 0);
        check_value("request after grant", 0, request[1]);
        repeat (3) pop_flit(1);
        end_test();
    endtask

    task automatic interleave_packets();
        int pkts_left [VC_NUM];
        int flits_left [VC_NUM];
        int cycles;
        int w;
        bit busy;
        begin_test("interleaved_vcs");
        foreach (pkts_left[v])
        begin
            pkts_left[v]  = 3;
            flits_left[v] = 0;
        end
        cycles = 0;
        busy   = 1'b1;
        while (busy && cycles < 180)
        begin
            for (int v = 0; v < VC_NUM; v++)
            begin
                if (request[v] && ($random(seed) % 2 != 0))
                begin
                    vc_valid[v] = 1'b1;
                    vc_new[v]   = `NOC_VC_SIZE'($unsigned($random(seed)));
                    granted[v]  = vc_new[v];
                end
            end
            w = $unsigned($random(seed)) % VC_NUM;
            if (on_off[w] && flits_left[w] > 0)
            begin
                flits_left[w]--;
                drive_flit(w, (flits_left[w] == 0) ? TAIL : BODY, random_payload());
            end
            else if (on_off[w] && pkts_left[w] > 0 && allocatable[w])
            begin
                // A new packet starts only on a free VC, as an upstream VC allocator would
                pkts_left[w]--;
                flits_left[w] = $unsigned($random(seed)) % 4;
                drive_flit(w, (flits_left[w] == 0) ? HEADTAIL : HEAD, random_payload());
            end
            vc_sel   = `NOC_VC_SIZE'($unsigned($random(seed)));
            sa_valid = ($random(seed) % 4 != 0);
            @(negedge clk);
            if (sa_valid && out_valid)
            begin
                compare_front(vc_sel);
            end
            step();
            link_valid = 1'b0;
            vc_valid   = '0;
            cycles++;
            busy = 1'b0;
            for (int v = 0; v < VC_NUM; v++)
            begin
                if (pkts_left[v] > 0 || flits_left[v] > 0 || model_q[v].size() > 0)
                begin
                    busy = 1'b1;
                end
            end
        end
        sa_valid = 1'b0;
        if (busy)
        begin
            $display("Test %s: flits still pending after %0d cycles", test_name, cycles);
            errors++;
        end
        end_test();
    endtask

    task automatic fill_to_off();
        begin_test("on_off");
        send_flit(0, HEAD, head_payload(3, 3));
        for (int i = 1; i < OFF_LEVEL; i++)
        begin
            check_value("on_off below threshold", 1, on_off[0]);
            send_flit(0, BODY, random_payload());
        end
        check_value("on_off at threshold", 0, on_off[0]);
        check_value("other VC on_off", 1, on_off[1]);
        grant_vc(0, 1);
        pop_flit(0);
        check_value("on_off after pop", 1, on_off[0]);
        check_value("other VC on_off", 1, on_off[1]);
        send_flit(0, TAIL, random_payload());
        while (model_q[0].size() > 0)
        begin
            pop_flit(0);
        end
        end_test();
    endtask

    task automatic end_packets();
        begin_test("packet_end");
        send_flit(0, HEADTAIL, head_payload(0, 0));
        grant_vc(0, 0);
        pop_flit(0);
        check_value("allocatable after headtail", 1, allocatable[0]);
        check_value("request after headtail", 0, request[0]);
        send_flit(1, HEAD, head_payload(1, 2));
        send_flit(1, TAIL, random_payload());
        vc_sel   = 1'b1;
        sa_valid = 1'b1;  // Pops on a VC still waiting for its grant
        repeat (2) step();
        sa_valid = 1'b0;
        check_value("request while unallocated", 1, request[1]);
        check_value("allocatable while unallocated", 0, allocatable[1]);
        grant_vc(1, 1);
        repeat (2) pop_flit(1);
        check_value("allocatable after tail", 1, allocatable[1]);
        check_value("request after tail", 0, request[1]);
        end_test();
    endtask

    initial
    begin
        seed         = 32'hfc45_848f;
        errors       = 0;
        errors_seen  = 0;
        tests_failed = 0;
        link_flit    = '0;
        link_valid   = 1'b0;
        vc_sel       = '0;
        sa_valid     = 1'b0;
        vc_valid     = '0;
        for (int v = 0; v < VC_NUM; v++)
        begin
            vc_new[v]  = '0;
            granted[v] = '0;
        end
        @(posedge arst_n);
        step();
        verify_reset_state();
        route_heads();
        allocate_vc();
        interleave_packets();
        fill_to_off();
        end_packets();
        $display("Tests passed: %0d, tests failed: %0d, errors: %0d",
                 NUM_TESTS - tests_failed, tests_failed, total_errors());
        if (total_errors() == 0 && tests_failed == 0)
        begin
            $display("Simulation passed");
        end
        else
        begin
            $display("Simulation failed");
        end
        $finish;
    end

    // Each test gets at most 200 clock cycles
    initial
    begin
        #(NUM_TESTS * 200 * CLK_PERIOD);
        $display("Watchdog expired before all tests finished");
        $display("Simulation failed");
        $finish;
    end

endmodule

`default_nettype wire

//--- input_port_chk.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module input_port_chk (
    input logic                     clk,
    input logic                     arst_n_i,
    input noc_pkg::flit_t           data_i,
    input logic                     valid_flit_i,
    input logic [`NOC_VC_SIZE-1:0]  vc_sel_i,
    input logic                     sa_valid_i,
    input logic [`NOC_VC_NUM-1:0]   vc_valid_i,
    input logic                     flit_valid_i,
    input logic [`NOC_VC_NUM-1:0]   on_off_i,
    input logic [`NOC_VC_NUM-1:0]   vc_request_i
);

    // Number of assertion failures so far
    int unsigned fail_count = 0;

    // Flits held per VC as seen from the link and the crossbar ports
    int unsigned occupancy [`NOC_VC_NUM];

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            for (int vc = 0; vc < `NOC_VC_NUM; vc++)
            begin
                occupancy[vc] <= 0;
            end
        end
        else
        begin
            for (int vc = 0; vc < `NOC_VC_NUM; vc++)
            begin
                occupancy[vc] <= occupancy[vc]
                                 + ((valid_flit_i && (data_i.vc_id == vc)) ? 1 : 0)
                                 - ((sa_valid_i && flit_valid_i && (vc_sel_i == vc)) ? 1 : 0);
            end
        end
    end

    // The crossbar never sees a valid flit from an empty buffer
    valid_from_filled_vc: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        flit_valid_i |-> (occupancy[vc_sel_i] != 0)
    )
    else
    begin
        $error("flit_valid_o is high while the selected VC buffer is empty");
        fail_count++;
    end

    // Upstream must respect the off state of the target VC
    write_only_when_on: assert property (
        @(posedge clk) disable iff (!arst_n_i)
        valid_flit_i |-> on_off_i[data_i.vc_id]
    )
    else
    begin
        $error("A flit was written to a VC whose on_off_o is low");
        fail_count++;
    end

    for (genvar vc = 0; vc < `NOC_VC_NUM; vc++)
    begin : g_vc
        request_drops_after_grant: assert property (
            @(posedge clk) disable iff (!arst_n_i)
            (vc_request_i[vc] && vc_valid_i[vc]) |=> !vc_request_i[vc]
        )
        else
        begin
            $error("vc_request_o of VC %0d stayed high after its grant", vc);
            fail_count++;
        end
    end

endmodule

bind input_port input_port_chk input_port_chk_i (
    .clk          (clk),
    .arst_n_i     (arst_n_i),
    .data_i       (data_i),
    .valid_flit_i (valid_flit_i),
    .vc_sel_i     (vc_sel_i),
    .sa_valid_i   (sa_valid_i),
    .vc_valid_i   (vc_valid_i),
    .flit_valid_i (flit_valid_o),
    .on_off_i     (on_off_o),
    .vc_request_i (vc_request_o)
);

`default_nettype wire

//--- tb_clk_gen.sv
`timescale 1ns/1ps
`default_nettype none

module tb_clk_gen #(
    parameter int PERIOD       = 10,
    parameter int RESET_CYCLES = 5
) (
    output logic clk_o,
    output logic arst_n_o
);

    initial
    begin
        clk_o    = 1'b0;
        arst_n_o = 1'b0;
        repeat (RESET_CYCLES) @(posedge clk_o);
        #1;
        arst_n_o = 1'b1;  // Released just after an edge so no flop sees it change
    end

    always #(PERIOD / 2) clk_o = ~clk_o;

endmodule

`default_nettype wire

//--- input_port.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module input_port #(
    parameter int X_CURRENT = `NOC_MESH_SIZE_X / 2,
    parameter int Y_CURRENT = `NOC_MESH_SIZE_Y / 2
) (
    input  logic                                  clk,
    input  logic                                  arst_n_i,
    input  noc_pkg::flit_t                        data_i,
    input  logic                                  valid_flit_i,
    input  logic [`NOC_VC_SIZE-1:0]               vc_sel_i,
    input  logic                                  sa_valid_i,
    input  logic [`NOC_VC_SIZE-1:0]               vc_new_i [`NOC_VC_NUM],
    input  logic [`NOC_VC_NUM-1:0]                vc_valid_i,
    output noc_pkg::flit_t                        flit_o,
    output logic                                  flit_valid_o,
    output logic [`NOC_VC_NUM-1:0]                on_off_o,
    output logic [`NOC_VC_NUM-1:0]                vc_allocatable_o,
    output logic [`NOC_VC_NUM-1:0]                vc_request_o,
    output noc_pkg::port_t [`NOC_VC_NUM-1:0]      out_port_o
);

    import noc_pkg::*;

    flit_t [`NOC_VC_NUM-1:0]  vc_data;
    port_t                    route_cmd;
    logic [`NOC_VC_NUM-1:0]   write_cmd;
    logic [`NOC_VC_NUM-1:0]   read_cmd;
    logic [`NOC_VC_NUM-1:0]   is_empty;
    logic [`NOC_VC_NUM-1:0]   vc_ready;

    // Every buffer sees the same route and only a head write latches it
    route_compute #(
        .X_CURRENT(X_CURRENT),
        .Y_CURRENT(Y_CURRENT)
    ) route_compute_i (
        .x_dest_i   (data_i.data.head_data.x_dest),
        .y_dest_i   (data_i.data.head_data.y_dest),
        .out_port_o (route_cmd)
    );

    for (genvar vc = 0; vc < `NOC_VC_NUM; vc++)
    begin : g_vc
        vc_buffer #(
            .BUFFER_SIZE(`NOC_BUFFER_SIZE)
        ) vc_buffer_i (
            .clk              (clk),
            .arst_n_i         (arst_n_i),
            .data_i           (data_i),
            .write_i          (write_cmd[vc]),
            .read_i           (read_cmd[vc]),
            .vc_new_i         (vc_new_i[vc]),
            .vc_valid_i       (vc_valid_i[vc]),
            .out_port_i       (route_cmd),
            .data_o           (vc_data[vc]),
            .is_empty_o       (is_empty[vc]),
            .on_off_o         (on_off_o[vc]),
            .out_port_o       (out_port_o[vc]),
            .vc_request_o     (vc_request_o[vc]),
            .vc_allocatable_o (vc_allocatable_o[vc]),
            .ready_o          (vc_ready[vc])
        );
    end

    // Write goes to the VC named in the incoming flit
    always_comb
    begin
        write_cmd = '0;
        if (valid_flit_i)
        begin
            write_cmd[data_i.vc_id] = 1'b1;
        end
    end

    always_comb
    begin
        read_cmd = '0;
        // No pop is issued to an empty buffer
        if (sa_valid_i && !is_empty[vc_sel_i])
        begin
            read_cmd[vc_sel_i] = 1'b1;
        end
    end

    assign flit_o       = vc_data[vc_sel_i];   // Front flit of the selected VC
    assign flit_valid_o = vc_ready[vc_sel_i];  // Allocated and holding a flit

endmodule

`default_nettype wire

//--- vc_buffer.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module vc_buffer #(
    parameter int BUFFER_SIZE = `NOC_BUFFER_SIZE
) (
    input  logic                     clk,
    input  logic                     arst_n_i,
    input  noc_pkg::flit_t           data_i,
    input  logic                     write_i,
    input  logic                     read_i,
    input  logic [`NOC_VC_SIZE-1:0]  vc_new_i,
    input  logic                     vc_valid_i,
    input  noc_pkg::port_t           out_port_i,
    output noc_pkg::flit_t           data_o,
    output logic                     is_empty_o,
    output logic                     on_off_o,
    output noc_pkg::port_t           out_port_o,
    output logic                     vc_request_o,
    output logic                     vc_allocatable_o,
    output logic                     ready_o
);

    import noc_pkg::*;

    localparam int PTR_W     = (BUFFER_SIZE > 1) ? $clog2(BUFFER_SIZE) : 1;
    localparam int CNT_W     = $clog2(BUFFER_SIZE + 1);
    localparam int OFF_LEVEL = BUFFER_SIZE - `NOC_ON_OFF_MARGIN;

    // Packet progress through the VC
    typedef enum logic [1:0]
    {
        IDLE,
        WAIT_VC,
        ACTIVE
    } state_e;

    flit_t                    mem [BUFFER_SIZE];
    flit_t                    front;
    logic [PTR_W-1:0]         wr_ptr;
    logic [PTR_W-1:0]         rd_ptr;
    logic [CNT_W-1:0]         count;
    logic                     is_empty;
    logic                     is_full;
    logic                     do_write;
    logic                     do_read;
    logic                     head_in;
    logic                     tail_out;
    state_e                   state;
    logic [`NOC_VC_SIZE-1:0]  vc_down;
    port_t                    route_q;

    // Circular pointer advance that also works for depths other than powers of two
    function automatic logic [PTR_W-1:0] ptr_next(input logic [PTR_W-1:0] ptr);
        if (ptr == PTR_W'(BUFFER_SIZE - 1))
        begin
            return '0;
        end
        return ptr + 1'b1;
    endfunction

    assign is_empty = (count == '0);
    assign is_full  = (count == CNT_W'(BUFFER_SIZE));

    assign ready_o  = (state == ACTIVE) && !is_empty;
    assign do_write = write_i && !is_full;
    assign do_read  = read_i && ready_o;   // Pops on a VC that is not ready do nothing

    assign head_in  = do_write &&
                      ((data_i.flit_type == HEAD) || (data_i.flit_type == HEADTAIL));
    assign tail_out = do_read &&
                      ((front.flit_type == TAIL) || (front.flit_type == HEADTAIL));

    always_ff @(posedge clk)
    begin
        if (do_write)
        begin
            mem[wr_ptr] <= data_i;
        end
    end

    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end
        else
        begin
            if (do_write)
            begin
                wr_ptr <= ptr_next(wr_ptr);
            end
            if (do_read)
            begin
                rd_ptr <= ptr_next(rd_ptr);
            end
            case ({do_write, do_read})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;  // Idle or a write and a read together
            endcase
        end
    end

    // Route and downstream VC are held for the whole packet
    always_ff @(posedge clk or negedge arst_n_i)
    begin
        if (!arst_n_i)
        begin
            state   <= IDLE;
            route_q <= LOCAL;
            vc_down <= '0;
        end
        else
        begin
            case (state)
                IDLE:
                begin
                    if (head_in)
                    begin
                        route_q <= out_port_i;
                        state   <= WAIT_VC;
                    end
                end
                WAIT_VC:
                begin
                    if (vc_valid_i)
                    begin
                        vc_down <= vc_new_i;
                        state   <= ACTIVE;
                    end
                end
                ACTIVE:
                begin
                    // The last flit of the packet frees the VC
                    if (tail_out)
                    begin
                        state <= IDLE;
                    end
                end
                default:
                begin
                    state <= IDLE;
                end
            endcase
        end
    end

    always_comb
    begin
        front        = mem[rd_ptr];
        data_o       = front;
        data_o.vc_id = vc_down;  // Downstream router sees the allocated VC
    end

    assign is_empty_o       = is_empty;
    assign on_off_o         = (count < CNT_W'(OFF_LEVEL));
    assign out_port_o       = route_q;
    assign vc_request_o     = (state == WAIT_VC);
    assign vc_allocatable_o = (state == IDLE) && is_empty;

endmodule

`default_nettype wire

//--- route_compute.sv
`timescale 1ns/1ps
`default_nettype none

`include "noc_params.svh"

module route_compute #(
    parameter int X_CURRENT = `NOC_MESH_SIZE_X / 2,
    parameter int Y_CURRENT = `NOC_MESH_SIZE_Y / 2
) (
    input  logic [`NOC_DEST_ADDR_SIZE_X-1:0] x_dest_i,
    input  logic [`NOC_DEST_ADDR_SIZE_Y-1:0] y_dest_i,
    output noc_pkg::port_t                   out_port_o
);

    import noc_pkg::*;

    // Router position at the coordinate widths
    localparam logic [`NOC_DEST_ADDR_SIZE_X-1:0] X_HERE = `NOC_DEST_ADDR_SIZE_X'(X_CURRENT);
    localparam logic [`NOC_DEST_ADDR_SIZE_Y-1:0] Y_HERE = `NOC_DEST_ADDR_SIZE_Y'(Y_CURRENT);

    logic x_greater;
    logic x_less;
    logic y_greater;
    logic y_less;

    assign x_greater = (x_dest_i > X_HERE);
    assign x_less    = (x_dest_i < X_HERE);
    assign y_greater = (y_dest_i > Y_HERE);  // Y grows towards the south edge
    assign y_less    = (y_dest_i < Y_HERE);

    // Dimension order routing resolves X completely before Y
    always_comb
    begin
        if (x_greater)
        begin
            out_port_o = EAST;
        end
        else if (x_less)
        begin
            out_port_o = WEST;
        end
        else if (y_greater)
        begin
            out_port_o = SOUTH;
        end
        else if (y_less)
        begin
            out_port_o = NORTH;
        end
        else
        begin
            out_port_o = LOCAL;  // Packet has reached its destination
        end
    end

endmodule

`default_nettype wire

//--- noc_pkg.sv
`default_nettype none

`include "noc_params.svh"

package noc_pkg;

    // Router output directions
    typedef enum logic [2:0]
    {
        LOCAL = 3'd0,
        NORTH = 3'd1,
        SOUTH = 3'd2,
        EAST  = 3'd3,
        WEST  = 3'd4
    } port_t;

    // Position of a flit inside its packet
    typedef enum logic [1:0]
    {
        HEAD     = 2'd0,
        BODY     = 2'd1,
        TAIL     = 2'd2,
        HEADTAIL = 2'd3
    } flit_type_e;

    // Unused low bits of the head view
    localparam int HEAD_PAD_WIDTH =
        `NOC_PAYLOAD_WIDTH - `NOC_DEST_ADDR_SIZE_X - `NOC_DEST_ADDR_SIZE_Y;

    typedef struct packed
    {
        logic [`NOC_DEST_ADDR_SIZE_X-1:0] x_dest;
        logic [`NOC_DEST_ADDR_SIZE_Y-1:0] y_dest;
        logic [HEAD_PAD_WIDTH-1:0]        pad;
    } head_data_t;

    // A head carries the destination and any other flit carries raw payload
    typedef union packed
    {
        head_data_t                     head_data;
        logic [`NOC_PAYLOAD_WIDTH-1:0]  bt_pl;
    } flit_data_u;

    typedef struct packed
    {
        flit_type_e               flit_type;
        logic [`NOC_VC_SIZE-1:0]  vc_id;     // VC on the link, rewritten on the way out
        flit_data_u               data;
    } flit_t;

endpackage

`default_nettype wire

//--- noc_params.svh
`ifndef NOC_PARAMS_SVH
`define NOC_PARAMS_SVH

// Mesh dimensions in routers
`define NOC_MESH_SIZE_X 4
`define NOC_MESH_SIZE_Y 4

// Destination coordinate widths carried by a head flit
`define NOC_DEST_ADDR_SIZE_X 2
`define NOC_DEST_ADDR_SIZE_Y 2

// Virtual channels per input port and the width of a VC id
`define NOC_VC_NUM  2
`define NOC_VC_SIZE 1

// Flit slots in each VC buffer
`define NOC_BUFFER_SIZE 8

// Slots kept free for flits already on the link when off is raised
`define NOC_ON_OFF_MARGIN 5

// Width of the flit payload word
`define NOC_PAYLOAD_WIDTH 16

`endif
